/* hdl/rv_bus_config.svh */
`ifndef RV_BUS_CONFIG_SVH
`define RV_BUS_CONFIG_SVH

// data path width
`define RV_XLEN 32

// first fetch address after reset
`define RV_RESET_PC 32'h0000_0100

// bus slaves answer with err_i at or above this byte address
`define RV_FAULT_BASE 32'h0000_4000

`endif

/* hdl/rv_bus_pkg.sv */
`default_nettype none

package rv_bus_pkg;

  // current owner of the shared wishbone master port
  typedef enum logic [1:0] {
    OWNER_NONE  = 2'd0,
    OWNER_MEM   = 2'd1,
    OWNER_FETCH = 2'd2,
    OWNER_EXT   = 2'd3
  } bus_owner_e;

  // load/store access width
  // 2'd3 is unused, the load/store unit treats it as a word
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2
  } access_size_e;

endpackage

`default_nettype wire

/* hdl/rv_prefetch.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_bus_config.svh"

module rv_prefetch (
  input  logic                 clk_i,
  input  logic                 reset_i,

  // instruction side
  input  logic                 instr_advance_i,
  input  logic                 redirect_i,
  input  logic [`RV_XLEN-1:0]  redirect_pc_i,
  output logic                 instr_valid_o,
  output logic [`RV_XLEN-1:0]  instr_o,
  output logic [`RV_XLEN-1:0]  instr_pc_o,
  output logic                 instr_fault_o,

  // bus side
  output logic                 req_o,
  input  logic                 grant_i,
  input  logic [`RV_XLEN-1:0]  bus_dat_i,
  input  logic                 ack_i,
  input  logic                 err_i,
  output logic [`RV_XLEN-3:0]  adr_o,
  output logic                 cyc_o,
  output logic                 stb_o
);

  logic [`RV_XLEN-1:0] fetch_pc;
  logic [`RV_XLEN-3:0] adr_q;
  logic [`RV_XLEN-1:0] buf_instr;
  logic                buf_valid;
  logic                buf_fault;
  logic                cyc_q;
  logic                discard_q;
  logic                bus_done;
  logic                consume;
  logic                start_fetch;

  assign bus_done    = cyc_q & (ack_i | err_i);
  assign consume     = instr_advance_i & buf_valid;
  // a redirect in this cycle would change the pointer under the new cycle
  assign start_fetch = grant_i & ~cyc_q & ~buf_valid & ~redirect_i;

  // hold req over the whole cycle, and across an advance to keep ownership
  assign req_o = cyc_q | ~buf_valid | instr_advance_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_pc  <= `RV_RESET_PC;
      buf_valid <= 1'b0;
      cyc_q     <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      // redirect wins over a sequential step
      if (redirect_i) begin
        fetch_pc <= redirect_pc_i;
      end else if (consume) begin
        fetch_pc <= fetch_pc + `RV_XLEN'(4);
      end

      if (redirect_i || consume) begin
        buf_valid <= 1'b0;
      end else if (bus_done && !discard_q) begin
        buf_valid <= 1'b1;
      end

      if (start_fetch) begin
        cyc_q <= 1'b1;
      end else if (bus_done) begin
        cyc_q <= 1'b0;
      end

      // word from an abandoned cycle is thrown away when it arrives
      if (bus_done) begin
        discard_q <= 1'b0;
      end else if (redirect_i && cyc_q) begin
        discard_q <= 1'b1;
      end
    end
  end

  // address frozen for the life of the cycle
  always_ff @(posedge clk_i) begin
    if (start_fetch) begin
      adr_q <= fetch_pc[`RV_XLEN-1:2];
    end
    if (bus_done) begin
      buf_instr <= bus_dat_i;
      buf_fault <= err_i;
    end
  end

  assign instr_valid_o = buf_valid;
  assign instr_o       = buf_instr;
  assign instr_pc_o    = fetch_pc;
  assign instr_fault_o = buf_fault;

  assign adr_o = adr_q;
  assign cyc_o = cyc_q;
  assign stb_o = cyc_q;

endmodule

`default_nettype wire

/* hdl/rv_load_store.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_bus_config.svh"

module rv_load_store
  import rv_bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  // four-phase command port
  input  logic                 ls_req_i,
  input  logic [`RV_XLEN-1:0]  ls_addr_i,
  input  logic [`RV_XLEN-1:0]  ls_wdata_i,
  input  access_size_e         ls_size_i,
  input  logic                 ls_write_i,
  input  logic                 ls_unsigned_i,
  output logic                 ls_ack_o,
  output logic [`RV_XLEN-1:0]  ls_rdata_o,
  output logic                 ls_err_o,

  // bus side
  output logic                 req_o,
  input  logic                 grant_i,
  input  logic [`RV_XLEN-1:0]  bus_dat_i,
  input  logic                 ack_i,
  input  logic                 err_i,
  output logic [`RV_XLEN-3:0]  adr_o,
  output logic [`RV_XLEN-1:0]  bus_dat_o,
  output logic [3:0]           sel_o,
  output logic                 we_o,
  output logic                 cyc_o,
  output logic                 stb_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_BUS,
    ST_ACK
  } ls_state_e;

  ls_state_e           state;
  logic [1:0]          offset;
  logic                misaligned;
  logic                bus_done;
  logic [`RV_XLEN-1:0] load_shifted;
  logic [`RV_XLEN-1:0] load_ext;

  assign offset   = ls_addr_i[1:0];
  assign bus_done = (state == ST_BUS) & (ack_i | err_i);

  // lane select, store replication and alignment
  always_comb begin
    misaligned = 1'b0;
    sel_o      = 4'b1111;
    bus_dat_o  = ls_wdata_i;
    case (ls_size_i)
      SIZE_BYTE: begin
        sel_o     = 4'b0001 << offset;
        bus_dat_o = {4{ls_wdata_i[7:0]}};
      end
      SIZE_HALF: begin
        misaligned = offset[0];
        sel_o      = offset[1] ? 4'b1100 : 4'b0011;
        bus_dat_o  = {2{ls_wdata_i[15:0]}};
      end
      default: begin
        misaligned = |offset;
      end
    endcase
  end

  // selected lane moved down to bit 0
  assign load_shifted = bus_dat_i >> {offset, 3'b000};

  always_comb begin
    case (ls_size_i)
      SIZE_BYTE: begin
        load_ext = {{(`RV_XLEN-8){~ls_unsigned_i & load_shifted[7]}},
                    load_shifted[7:0]};
      end
      SIZE_HALF: begin
        load_ext = {{(`RV_XLEN-16){~ls_unsigned_i & load_shifted[15]}},
                    load_shifted[15:0]};
      end
      default: begin
        load_ext = load_shifted;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state <= ST_IDLE;
    end else begin
      case (state)
        ST_IDLE: begin
          // misaligned accesses never reach the bus
          if (ls_req_i) begin
            state <= misaligned ? ST_ACK : ST_REQ;
          end
        end
        ST_REQ: begin
          if (grant_i) begin
            state <= ST_BUS;
          end
        end
        ST_BUS: begin
          if (ack_i || err_i) begin
            state <= ST_ACK;
          end
        end
        default: begin
          if (!ls_req_i) begin
            state <= ST_IDLE;
          end
        end
      endcase
    end
  end

  // result captured at bus termination, or at acceptance for a misaligned access
  always_ff @(posedge clk_i) begin
    if (state == ST_IDLE) begin
      ls_err_o   <= misaligned;
      ls_rdata_o <= '0;
    end else if (bus_done) begin
      ls_err_o   <= err_i;
      ls_rdata_o <= load_ext;
    end
  end

  assign ls_ack_o = (state == ST_ACK);
  assign req_o    = (state == ST_REQ) | (state == ST_BUS);
  assign adr_o    = ls_addr_i[`RV_XLEN-1:2];
  assign cyc_o    = (state == ST_BUS);
  assign stb_o    = (state == ST_BUS);
  assign we_o     = (state == ST_BUS) & ls_write_i;

endmodule

`default_nettype wire

/* hdl/rv_bus_arbiter.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_bus_config.svh"

module rv_bus_arbiter
  import rv_bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  input  logic                 mem_req_i,
  input  logic                 fetch_req_i,
  input  logic                 ext_req_i,

  // load/store bus signals
  input  logic [`RV_XLEN-3:0]  mem_adr_i,
  input  logic [`RV_XLEN-1:0]  mem_dat_i,
  input  logic [3:0]           mem_sel_i,
  input  logic                 mem_we_i,
  input  logic                 mem_cyc_i,
  input  logic                 mem_stb_i,

  // prefetch bus signals, always full word reads
  input  logic [`RV_XLEN-3:0]  fetch_adr_i,
  input  logic                 fetch_cyc_i,
  input  logic                 fetch_stb_i,

  output logic                 mem_grant_o,
  output logic                 fetch_grant_o,
  output logic                 ctrl_grant_o,

  output logic [`RV_XLEN-3:0]  adr_o,
  output logic [`RV_XLEN-1:0]  dat_o,
  output logic [3:0]           sel_o,
  output logic                 we_o,
  output logic                 cyc_o,
  output logic                 stb_o
);

  bus_owner_e owner;

  // fetch is the default owner
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      owner <= OWNER_FETCH;
    end else begin
      case (owner)
        OWNER_NONE: begin
          if (mem_req_i) begin
            owner <= OWNER_MEM;
          end else if (fetch_req_i) begin
            owner <= OWNER_FETCH;
          end else if (ext_req_i) begin
            owner <= OWNER_EXT;
          end else begin
            owner <= OWNER_FETCH;
          end
        end
        OWNER_FETCH: begin
          if (!fetch_req_i) begin
            if (mem_req_i) begin
              owner <= OWNER_MEM;
            end else if (ext_req_i) begin
              owner <= OWNER_EXT;
            end
          end
        end
        OWNER_MEM: begin
          if (!mem_req_i) begin
            owner <= OWNER_FETCH;
          end
        end
        default: begin
          if (!ext_req_i) begin
            owner <= OWNER_FETCH;
          end
        end
      endcase
    end
  end

  assign mem_grant_o   = (owner == OWNER_MEM);
  assign fetch_grant_o = (owner == OWNER_FETCH);
  assign ctrl_grant_o  = (owner == OWNER_EXT);

  // only the load/store unit writes
  assign dat_o = mem_dat_i;

  always_comb begin
    adr_o = mem_adr_i;
    sel_o = mem_sel_i;
    we_o  = 1'b0;
    cyc_o = 1'b0;
    stb_o = 1'b0;
    case (owner)
      OWNER_FETCH: begin
        adr_o = fetch_adr_i;
        sel_o = 4'b1111;
        cyc_o = fetch_cyc_i;
        stb_o = fetch_stb_i;
      end
      OWNER_MEM: begin
        we_o  = mem_we_i;
        cyc_o = mem_cyc_i;
        stb_o = mem_stb_i;
      end
      // external master drives the wires outside this design
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/rv_bus_subsystem.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_bus_config.svh"

module rv_bus_subsystem
  import rv_bus_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 reset_i,

  // instruction port
  input  logic                 instr_advance_i,
  input  logic                 redirect_i,
  input  logic [`RV_XLEN-1:0]  redirect_pc_i,
  output logic                 instr_valid_o,
  output logic [`RV_XLEN-1:0]  instr_o,
  output logic [`RV_XLEN-1:0]  instr_pc_o,
  output logic                 instr_fault_o,

  // load/store command port
  input  logic                 ls_req_i,
  input  logic [`RV_XLEN-1:0]  ls_addr_i,
  input  logic [`RV_XLEN-1:0]  ls_wdata_i,
  input  access_size_e         ls_size_i,
  input  logic                 ls_write_i,
  input  logic                 ls_unsigned_i,
  output logic                 ls_ack_o,
  output logic [`RV_XLEN-1:0]  ls_rdata_o,
  output logic                 ls_err_o,

  // wishbone classic master
  input  logic [`RV_XLEN-1:0]  dat_i,
  output logic [`RV_XLEN-1:0]  dat_o,
  output logic [`RV_XLEN-3:0]  adr_o,
  output logic [3:0]           sel_o,
  output logic                 we_o,
  output logic                 cyc_o,
  output logic                 stb_o,
  input  logic                 ack_i,
  input  logic                 err_i,

  // external bus request
  input  logic                 ctrl_req_i,
  output logic                 ctrl_grant_o
);

  logic                fetch_req;
  logic                fetch_grant;
  logic [`RV_XLEN-3:0] fetch_adr;
  logic                fetch_cyc;
  logic                fetch_stb;

  logic                mem_req;
  logic                mem_grant;
  logic [`RV_XLEN-3:0] mem_adr;
  logic [`RV_XLEN-1:0] mem_dat;
  logic [3:0]          mem_sel;
  logic                mem_we;
  logic                mem_cyc;
  logic                mem_stb;

  rv_prefetch u_prefetch (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .instr_advance_i (instr_advance_i),
    .redirect_i      (redirect_i),
    .redirect_pc_i   (redirect_pc_i),
    .instr_valid_o   (instr_valid_o),
    .instr_o         (instr_o),
    .instr_pc_o      (instr_pc_o),
    .instr_fault_o   (instr_fault_o),
    .req_o           (fetch_req),
    .grant_i         (fetch_grant),
    .bus_dat_i       (dat_i),
    .ack_i           (ack_i),
    .err_i           (err_i),
    .adr_o           (fetch_adr),
    .cyc_o           (fetch_cyc),
    .stb_o           (fetch_stb)
  );

  rv_load_store u_load_store (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .ls_req_i      (ls_req_i),
    .ls_addr_i     (ls_addr_i),
    .ls_wdata_i    (ls_wdata_i),
    .ls_size_i     (ls_size_i),
    .ls_write_i    (ls_write_i),
    .ls_unsigned_i (ls_unsigned_i),
    .ls_ack_o      (ls_ack_o),
    .ls_rdata_o    (ls_rdata_o),
    .ls_err_o      (ls_err_o),
    .req_o         (mem_req),
    .grant_i       (mem_grant),
    .bus_dat_i     (dat_i),
    .ack_i         (ack_i),
    .err_i         (err_i),
    .adr_o         (mem_adr),
    .bus_dat_o     (mem_dat),
    .sel_o         (mem_sel),
    .we_o          (mem_we),
    .cyc_o         (mem_cyc),
    .stb_o         (mem_stb)
  );

  rv_bus_arbiter u_arbiter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .mem_req_i     (mem_req),
    .fetch_req_i   (fetch_req),
    .ext_req_i     (ctrl_req_i),
    .mem_adr_i     (mem_adr),
    .mem_dat_i     (mem_dat),
    .mem_sel_i     (mem_sel),
    .mem_we_i      (mem_we),
    .mem_cyc_i     (mem_cyc),
    .mem_stb_i     (mem_stb),
    .fetch_adr_i   (fetch_adr),
    .fetch_cyc_i   (fetch_cyc),
    .fetch_stb_i   (fetch_stb),
    .mem_grant_o   (mem_grant),
    .fetch_grant_o (fetch_grant),
    .ctrl_grant_o  (ctrl_grant_o),
    .adr_o         (adr_o),
    .dat_o         (dat_o),
    .sel_o         (sel_o),
    .we_o          (we_o),
    .cyc_o         (cyc_o),
    .stb_o         (stb_o)
  );

endmodule

`default_nettype wire

/* dv/tb_clock_gen.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
  parameter real PERIOD_NS    = 8.0,
  parameter int  RESET_CYCLES = 8
) (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

  always #(PERIOD_NS / 2.0) clk_o = ~clk_o;

endmodule

`default_nettype wire

/* dv/wb_memory_model.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_bus_config.svh"

module wb_memory_model #(
  parameter logic [31:0] PRELOAD_KEY = 32'h5A3C_96E1
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic [`RV_XLEN-3:0] adr_i,
  input  logic [`RV_XLEN-1:0] dat_i,
  input  logic [3:0]          sel_i,
  input  logic                we_i,
  input  logic                cyc_i,
  input  logic                stb_i,
  output logic [`RV_XLEN-1:0] dat_o,
  output logic                ack_o,
  output logic                err_o
);

  logic [31:0] mem [0:4095];
  logic [1:0]  wait_cnt;
  logic [31:0] rnd;
  logic [31:0] byte_adr;
  int          seed;
  int          i;

  // each word holds its own byte address scrambled by the key
  initial begin
    seed = 13712;
    for (i = 0; i < 4096; i++) begin
      mem[i] = (32'(i) << 2) ^ PRELOAD_KEY;
    end
  end

  assign byte_adr = {adr_i, 2'b00};

  always @(posedge clk_i) begin
    rnd = $random(seed);
    if (reset_i) begin
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      wait_cnt <= rnd[1:0];
    end else if (ack_o || err_o) begin
      ack_o    <= 1'b0;
      err_o    <= 1'b0;
      wait_cnt <= rnd[1:0];
    end else if (cyc_i && stb_i) begin
      if (wait_cnt != 2'd0) begin
        wait_cnt <= wait_cnt - 2'd1;
      end else if (byte_adr >= `RV_FAULT_BASE) begin
        err_o <= 1'b1;
      end else begin
        ack_o <= 1'b1;
        dat_o <= mem[adr_i[11:0]];
        for (i = 0; i < 4; i++) begin
          if (we_i && sel_i[i]) begin
            mem[adr_i[11:0]][8*i +: 8] <= dat_i[8*i +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

/* dv/rv_bus_subsystem_tb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "rv_bus_config.svh"

module rv_bus_subsystem_tb
  import rv_bus_pkg::*;
();

  localparam logic [31:0] KEY     = 32'h5A3C_96E1;
  localparam int          TIMEOUT = 400;

  logic clk, reset;
  logic advance, redirect, ctrl_req, ls_req, ls_write, ls_uns;
  logic [31:0] redirect_pc, ls_addr, ls_wdata;
  access_size_e ls_size;
  logic instr_valid, instr_fault, ls_ack, ls_err, ctrl_grant;
  logic [31:0] instr, instr_pc, ls_rdata, m_dat_i, m_dat_o;
  logic [29:0] adr;
  logic [3:0]  sel;
  logic we, cyc, stb, ack, err;

  logic [31:0] shadow [0:4095];
  logic [3:0]  last_sel;
  logic [31:0] exp_pc, rd;
  logic        rerr;
  int ls_cycles, errors, failed_tests, seed, k, sz, off, uns, start_err, rule_errors;

  tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(8)) u_clk (.clk_o(clk), .reset_o(reset));

  wb_memory_model #(.PRELOAD_KEY(KEY)) u_mem (
    .clk_i(clk), .reset_i(reset), .adr_i(adr), .dat_i(m_dat_o), .sel_i(sel), .we_i(we),
    .cyc_i(cyc), .stb_i(stb), .dat_o(m_dat_i), .ack_o(ack), .err_o(err)
  );

  rv_bus_subsystem u_dut (
    .clk_i(clk), .reset_i(reset), .instr_advance_i(advance), .redirect_i(redirect),
    .redirect_pc_i(redirect_pc), .instr_valid_o(instr_valid), .instr_o(instr),
    .instr_pc_o(instr_pc), .instr_fault_o(instr_fault), .ls_req_i(ls_req),
    .ls_addr_i(ls_addr), .ls_wdata_i(ls_wdata), .ls_size_i(ls_size), .ls_write_i(ls_write),
    .ls_unsigned_i(ls_uns), .ls_ack_o(ls_ack), .ls_rdata_o(ls_rdata), .ls_err_o(ls_err),
    .dat_i(m_dat_i), .dat_o(m_dat_o), .adr_o(adr), .sel_o(sel), .we_o(we), .cyc_o(cyc),
    .stb_o(stb), .ack_i(ack), .err_i(err), .ctrl_req_i(ctrl_req), .ctrl_grant_o(ctrl_grant)
  );

  // bus cycles that belong to the current load/store command
  always @(posedge clk) begin
    if (reset) begin
      ls_cycles <= 0;
      last_sel  <= 4'h0;
    end else if (cyc && stb && ls_req && (we || adr == ls_addr[31:2])) begin
      ls_cycles <= ls_cycles + 1;
      last_sel  <= sel;
    end
  end

  a_ack_rise: assert property (@(posedge clk) disable iff (reset)
                               $rose(ls_ack) |-> $past(ls_req))
    else begin
      $display("Mismatch: ls_ack_o=%h rose while ls_req_i was low", ls_ack);
      rule_errors++;
    end

  a_ack_fall: assert property (@(posedge clk) disable iff (reset)
                               $fell(ls_ack) |-> !$past(ls_req))
    else begin
      $display("Mismatch: ls_ack_o=%h fell while ls_req_i was high", ls_ack);
      rule_errors++;
    end

  // a write cycle only ever belongs to the current store command
  a_fetch_we: assert property (@(posedge clk) disable iff (reset)
                               (cyc && we) |-> (ls_req && ls_write && adr == ls_addr[31:2]))
    else begin
      $display("Mismatch: we_o=%h on a bus cycle at adr_o=%h", we, adr);
      rule_errors++;
    end

  a_cyc_stb: assert property (@(posedge clk) disable iff (reset) cyc |-> stb)
    else begin
      $display("Mismatch: cyc_o=%h stb_o=%h", cyc, stb);
      rule_errors++;
    end

  a_ext_idle: assert property (@(posedge clk) disable iff (reset) ctrl_grant |-> !cyc)
    else begin
      $display("Mismatch: cyc_o=%h while ctrl_grant_o=%h", cyc, ctrl_grant);
      errors++;
    end

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
      else begin
        $display("Mismatch: %s got %h expected %h", name, got, exp);
        errors++;
      end
  endtask

  task automatic wait_instr();
    int n;
    n = 0;
    while (!instr_valid && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!instr_valid) begin
      $display("timeout: no valid instruction appeared");
      errors++;
    end
  endtask

  task automatic check_instr(input logic [31:0] pc, input logic fault);
    wait_instr();
    check_value("instr_pc_o", instr_pc, pc);
    check_value("instr_fault_o", 32'(instr_fault), 32'(fault));
    if (!fault) check_value("instr_o", instr, pc ^ KEY);
  endtask

  task automatic advance_one();
    advance = 1'b1;
    @(negedge clk);
    advance = 1'b0;
    exp_pc = exp_pc + 32'd4;
  endtask

  task automatic redirect_to(input logic [31:0] pc);
    redirect = 1'b1;
    redirect_pc = pc;
    @(negedge clk);
    redirect = 1'b0;
    exp_pc = pc;
  endtask

  task automatic ls_start(input logic [31:0] a, input logic [31:0] d, input int s,
                          input logic w, input logic u);
    ls_addr = a;
    ls_wdata = d;
    ls_size = access_size_e'(s);
    ls_write = w;
    ls_uns = u;
    ls_req = 1'b1;
  endtask

  task automatic ls_finish(output logic [31:0] data, output logic e);
    int n;
    n = 0;
    while (!ls_ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!ls_ack) begin
      $display("timeout: load/store unit never acknowledged the command");
      errors++;
    end
    data = ls_rdata;
    e = ls_err;
    ls_req = 1'b0;
    n = 0;
    @(negedge clk);
    while (ls_ack && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (ls_ack) begin
      $display("timeout: ls_ack_o stayed high after the request dropped");
      errors++;
    end
  endtask

  task automatic ls_op(input logic [31:0] a, input logic [31:0] d, input int s,
                       input logic w, input logic u, output logic [31:0] data, output logic e);
    ls_start(a, d, s, w, u);
    @(negedge clk);
    ls_finish(data, e);
  endtask

  function automatic logic [31:0] expected_load(input logic [31:0] word, input int o,
                                                input int s, input int u);
    logic [7:0]  b;
    logic [15:0] h;
    b = word[8*o +: 8];
    h = word[8*o +: 16];
    if (s == 0) return u ? {24'h0, b} : {{24{b[7]}}, b};
    if (s == 1) return u ? {16'h0, h} : {{16{h[15]}}, h};
    return word;
  endfunction

  function automatic logic [3:0] expected_sel(input int s, input int o);
    if (s == 0) return 4'(1 << o);
    if (s == 1) return 4'(3 << o);
    return 4'hf;
  endfunction

  task automatic report_test(input string name);
    if (errors != start_err) failed_tests++;
    $display("test %-20s %s (%0d errors)", name, (errors == start_err) ? "ok" : "failed",
             errors - start_err);
    start_err = errors;
  endtask

  initial begin
    advance = 0;
    redirect = 0;
    redirect_pc = 0;
    ctrl_req = 0;
    ls_req = 0;
    ls_addr = 0;
    ls_wdata = 0;
    ls_size = SIZE_WORD;
    ls_write = 0;
    ls_uns = 0;
    errors = 0;
    rule_errors = 0;
    failed_tests = 0;
    start_err = 0;
    seed = 13712;
    for (k = 0; k < 4096; k++) shadow[k] = (32'(k) << 2) ^ KEY;
    k = 0;
    @(negedge clk);
    while (reset && k < TIMEOUT) begin
      @(negedge clk);
      k++;
    end
    if (reset) begin
      $display("timeout: reset was never released");
      errors++;
    end
    check_value("ls_ack_o", 32'(ls_ack), 32'h0);
    check_value("instr_valid_o", 32'(instr_valid), 32'h0);
    check_value("ctrl_grant_o", 32'(ctrl_grant), 32'h0);

    // sequential fetch from the reset vector
    exp_pc = `RV_RESET_PC;
    for (k = 0; k < 6; k++) begin
      check_instr(exp_pc, 1'b0);
      advance_one();
    end
    check_instr(exp_pc, 1'b0);
    report_test("sequential_fetch");

    // redirect with full buffer, then one during an open fetch cycle
    redirect_to(32'h0000_0800);
    check_instr(exp_pc, 1'b0);
    advance_one();
    k = 0;
    while (!cyc && k < TIMEOUT) begin
      @(negedge clk);
      k++;
    end
    if (!cyc) begin
      $display("timeout: no fetch cycle opened after advance");
      errors++;
    end
    redirect_to(32'h0000_0C40);
    check_instr(exp_pc, 1'b0);
    report_test("redirect");

    // stores then signed and unsigned loads at every legal offset
    // first store waits behind a fetch refill
    advance_one();
    for (sz = 0; sz < 3; sz++) begin
      for (off = 0; off < 4; off++) begin
        if ((sz == 1 && off[0]) || (sz == 2 && off != 0)) continue;
        ls_addr = 32'h2000 + 32'(sz * 16) + 32'(off);
        ls_wdata = $random(seed);
        // lane sign bits set so signed and unsigned loads differ
        ls_wdata = ls_wdata | 32'h0000_8080;
        ls_op(ls_addr, ls_wdata, sz, 1'b1, 1'b0, rd, rerr);
        check_value("ls_err_o", 32'(rerr), 32'h0);
        check_value("sel_o", 32'(last_sel), 32'(expected_sel(sz, off)));
        for (k = 0; k < 4; k++) begin
          if (expected_sel(sz, off) & 4'(1 << k)) begin
            shadow[ls_addr[13:2]][8*k +: 8] = ls_wdata[8*(k-off) +: 8];
          end
        end
        for (uns = 0; uns < 2; uns++) begin
          ls_op(ls_addr, 32'h0, sz, 1'b0, uns[0], rd, rerr);
          check_value("ls_err_o", 32'(rerr), 32'h0);
          check_value("sel_o", 32'(last_sel), 32'(expected_sel(sz, off)));
          check_value("ls_rdata_o", rd, expected_load(shadow[ls_addr[13:2]], off, sz, uns));
        end
      end
    end
    report_test("load_store");

    // misaligned commands stay off the bus and the fault region answers with err
    for (k = 0; k < 10; k++) begin
      sz = (k % 5 < 2) ? 1 : 2;
      off = (k % 5 == 0) ? 1 : (k % 5 == 1) ? 3 : (k % 5) - 1;
      uns = ls_cycles;
      ls_op(32'h2100 + 32'(off), 32'hDEAD_BEEF, sz, k < 5, 1'b0, rd, rerr);
      check_value("ls_err_o", 32'(rerr), 32'h1);
      check_value("bus cycles", 32'(ls_cycles), 32'(uns));
    end
    ls_op(`RV_FAULT_BASE + 32'h8, 32'h0, 2, 1'b0, 1'b0, rd, rerr);
    check_value("ls_err_o", 32'(rerr), 32'h1);
    ls_op(`RV_FAULT_BASE + 32'h21, 32'h55, 0, 1'b1, 1'b0, rd, rerr);
    check_value("ls_err_o", 32'(rerr), 32'h1);
    redirect_to(`RV_FAULT_BASE + 32'h10);
    check_instr(exp_pc, 1'b1);
    redirect_to(`RV_RESET_PC + 32'h40);
    check_instr(exp_pc, 1'b0);
    report_test("misaligned_fault");

    // external master takes the bus while a load waits
    ctrl_req = 1'b1;
    k = 0;
    while (!ctrl_grant && k < TIMEOUT) begin
      @(negedge clk);
      k++;
    end
    if (!ctrl_grant) begin
      $display("timeout: external master was never granted the bus");
      errors++;
    end
    ls_start(32'h2000, 32'h0, 2, 1'b0, 1'b0);
    repeat (16) begin
      @(negedge clk);
      check_value("ctrl_grant_o", 32'(ctrl_grant), 32'h1);
      check_value("ls_ack_o", 32'(ls_ack), 32'h0);
    end
    ctrl_req = 1'b0;
    ls_finish(rd, rerr);
    check_value("ls_err_o", 32'(rerr), 32'h0);
    check_value("ls_rdata_o", rd, shadow[32'h2000 >> 2]);
    advance_one();
    check_instr(exp_pc, 1'b0);
    report_test("external_master");

    // handshake rule violations collected over the whole run
    errors = errors + rule_errors;
    report_test("handshake_rules");

    $display("tests run 6, tests failed %0d, errors %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+hdl
hdl/rv_bus_pkg.sv
hdl/rv_prefetch.sv
hdl/rv_load_store.sv
hdl/rv_bus_arbiter.sv
hdl/rv_bus_subsystem.sv
dv/tb_clock_gen.sv
dv/wb_memory_model.sv
dv/rv_bus_subsystem_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module rv_bus_subsystem_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

output="$(./obj_dir/Vrv_bus_subsystem_tb)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qxF "TESTBENCH PASSED"; then
  exit 0
fi
exit 1
